// ==== src/amon_cfg.svh ====
// sizing macros for the reservation unit, included by every package and module that needs them.
`ifndef AMON_CFG_SVH
`define AMON_CFG_SVH

// harts sharing the request port, one monitor each.
`define AMON_HARTS 4

// nested reservations per hart, must stay a power of two.
`define AMON_DEPTH 4

// address width.
`define AMON_XLEN 32

`endif

// ==== src/isa_pkg.sv ====
// RISC-V encodings and the instruction word union, imported by the access decoder.
package isa_pkg;

	// major opcodes seen on the request port.
	typedef enum logic [6:0] {
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		ATOMIC = 7'b0101111
	} opcode_e;

	// A-extension funct5, everything past SC is a plain AMO.
	typedef enum logic [4:0] {
		AMOADD  = 5'b00000,
		AMOSWAP = 5'b00001,
		LR      = 5'b00010,
		SC      = 5'b00011,
		AMOXOR  = 5'b00100,
		AMOOR   = 5'b01000,
		AMOAND  = 5'b01100,
		AMOMIN  = 5'b10000,
		AMOMAX  = 5'b10100,
		AMOMINU = 5'b11000,
		AMOMAXU = 5'b11100
	} funct5_e;

	typedef struct packed {
		funct5_e    funct5;
		logic       aq;     // acquire ordering.
		logic       rl;     // release ordering.
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} amo_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} st_fmt_t;

	// same 32 bits, read as atomic or as store.
	typedef union packed {
		amo_fmt_t amo_fmt;
		st_fmt_t  st_fmt;
	} instr_word_u;

endpackage : isa_pkg

// ==== src/mon_pkg.sv ====
// monitor-side types for addresses, hart indices and reservation entries, shared by all modules.
`include "amon_cfg.svh"

package mon_pkg;

	// byte address of an access.
	typedef logic [`AMON_XLEN-1:0] addr_t;

	// index of the issuing hart.
	typedef logic [$clog2(`AMON_HARTS)-1:0] hart_t;

	// one slot of a hart's reservation stack.
	typedef struct packed {
		addr_t addr;
		logic  valid;
	} res_entry_t;

endpackage : mon_pkg

// ==== src/access_decoder.sv ====
// registers the shared access and fans it out as per-hart LR/SC strobes and a broadcast write strobe.
`timescale 1ns/100ps
`include "amon_cfg.svh"

module access_decoder (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     update,     // one-cycle access strobe.
	input  mon_pkg::hart_t           hart,
	input  isa_pkg::instr_word_u     instr,
	input  mon_pkg::addr_t           addr,
	output logic [`AMON_HARTS-1:0]   lr_strobe,
	output logic [`AMON_HARTS-1:0]   sc_strobe,
	output logic                     wr_strobe,
	output mon_pkg::addr_t           addr_q
);

	import isa_pkg::*;

	logic                   is_atomic;
	logic                   is_lr;
	logic                   is_sc;
	logic                   is_store;
	logic                   is_write;
	logic [`AMON_HARTS-1:0] hart_sel;

	always_comb begin
		// atomic view gives the A-extension operation.
		is_atomic = instr.amo_fmt.opcode == ATOMIC;
		is_lr     = is_atomic && (instr.amo_fmt.funct5 == LR);
		is_sc     = is_atomic && (instr.amo_fmt.funct5 == SC);
		// store view for plain stores.
		is_store  = instr.st_fmt.opcode == STORE;
		// SC and every AMO modify memory, LR does not.
		is_write  = is_store || (is_atomic && !is_lr);
		hart_sel  = `AMON_HARTS'(1) << hart;   // one-hot issuing hart.
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			lr_strobe <= '0;
			sc_strobe <= '0;
			wr_strobe <= 1'b0;
		end else begin
			lr_strobe <= (update && is_lr) ? hart_sel : '0;   // issuing hart only.
			sc_strobe <= (update && is_sc) ? hart_sel : '0;
			wr_strobe <= update && is_write;                   // seen by every monitor.
		end
	end

	// address travels with the strobes.
	always_ff @(posedge clk) begin
		if (update) begin
			addr_q <= addr;
		end
	end

endmodule : access_decoder

// ==== src/exclusive_monitor.sv ====
// per-hart reservation stack, cleared by matching writes and popped by SC to report success.
`timescale 1ns/100ps
`include "amon_cfg.svh"

module exclusive_monitor (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           lr_strobe,    // push a reservation.
	input  logic           sc_strobe,    // pop and test the newest one.
	input  logic           wr_strobe,    // any hart wrote addr.
	input  mon_pkg::addr_t addr,
	output logic           success
);

	import mon_pkg::*;

	localparam int PTR_W = $clog2(`AMON_DEPTH);

	res_entry_t       stack [`AMON_DEPTH];
	logic [PTR_W-1:0] ptr;       // newest entry, all ones when empty.
	logic [PTR_W-1:0] ptr_push;
	res_entry_t       top;
	logic             addr_hit;

	always_comb begin
		ptr_push = ptr + 1'b1;   // wraps with the power of two depth.
		top      = stack[ptr];
		// word compare, byte offset ignored.
		addr_hit = addr[`AMON_XLEN-1:2] == top.addr[`AMON_XLEN-1:2];
		success  = sc_strobe && addr_hit && top.valid;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '1;
		end else if (lr_strobe) begin
			ptr <= ptr_push;
		end else if (sc_strobe) begin
			ptr <= ptr - 1'b1;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `AMON_DEPTH; i++) begin
				stack[i] <= '0;
			end
		end else if (lr_strobe) begin
			stack[ptr_push].addr  <= addr;
			stack[ptr_push].valid <= 1'b1;
		end else if (wr_strobe && addr_hit) begin
			// another store hit the lock word.
			stack[ptr].valid <= 1'b0;
		end
	end

endmodule : exclusive_monitor

// ==== src/sc_result_collector.sv ====
// merges the per-hart SC outcomes into one registered result tagged with the issuing hart.
`timescale 1ns/100ps
`include "amon_cfg.svh"

module sc_result_collector (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`AMON_HARTS-1:0] sc_strobe,
	input  logic [`AMON_HARTS-1:0] success,
	output logic                   result_valid,
	output logic                   result_success,
	output mon_pkg::hart_t         result_hart
);

	import mon_pkg::*;

	logic  sc_any;
	hart_t sc_idx;

	always_comb begin
		sc_any = |sc_strobe;
		sc_idx = '0;
		// at most one bit set, plain encoder.
		for (int h = 0; h < `AMON_HARTS; h++) begin
			if (sc_strobe[h]) begin
				sc_idx = hart_t'(h);
			end
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			result_valid   <= 1'b0;
			result_success <= 1'b0;
		end else begin
			result_valid   <= sc_any;
			result_success <= |success;   // success only rises with its strobe.
		end
	end

	always_ff @(posedge clk) begin
		if (sc_any) begin
			result_hart <= sc_idx;
		end
	end

endmodule : sc_result_collector

// ==== src/atomic_monitor_top.sv ====
// top of the reservation unit, decoder feeding one monitor per hart and the result collector.
`timescale 1ns/100ps
`include "amon_cfg.svh"

module atomic_monitor_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 update,
	input  mon_pkg::hart_t       hart,
	input  isa_pkg::instr_word_u instr,
	input  mon_pkg::addr_t       addr,
	output logic                 result_valid,
	output logic                 result_success,
	output mon_pkg::hart_t       result_hart
);

	import mon_pkg::*;

	logic [`AMON_HARTS-1:0] lr_strobe;
	logic [`AMON_HARTS-1:0] sc_strobe;
	logic                   wr_strobe;
	addr_t                  addr_q;
	logic [`AMON_HARTS-1:0] success;

	access_decoder u_decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.update    (update),
		.hart      (hart),
		.instr     (instr),
		.addr      (addr),
		.lr_strobe (lr_strobe),
		.sc_strobe (sc_strobe),
		.wr_strobe (wr_strobe),
		.addr_q    (addr_q)
	);

	// one monitor per hart, writes broadcast to all.
	for (genvar g = 0; g < `AMON_HARTS; g++) begin : g_mon
		exclusive_monitor u_mon (
			.clk       (clk),
			.rst_n     (rst_n),
			.lr_strobe (lr_strobe[g]),
			.sc_strobe (sc_strobe[g]),
			.wr_strobe (wr_strobe),
			.addr      (addr_q),
			.success   (success[g])
		);
	end

	sc_result_collector u_collector (
		.clk            (clk),
		.rst_n          (rst_n),
		.sc_strobe      (sc_strobe),
		.success        (success),
		.result_valid   (result_valid),
		.result_success (result_success),
		.result_hart    (result_hart)
	);

endmodule : atomic_monitor_top

// ==== bench/atomic_monitor_props.sv ====
// concurrent checks on strobe and result rules, bound into the reservation unit top level.
`timescale 1ns/100ps
`include "amon_cfg.svh"

module atomic_monitor_props (
	input logic                   clk,
	input logic                   rst_n,
	input logic [`AMON_HARTS-1:0] lr_strobe,
	input logic [`AMON_HARTS-1:0] sc_strobe,
	input logic                   result_valid,
	input logic                   result_success
);

	// one access per cycle, so one hart at most.
	a_lr_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lr_strobe))
		else $error("lr_strobe has more than one hart selected");

	a_sc_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sc_strobe))
		else $error("sc_strobe has more than one hart selected");

	a_success_valid: assert property (@(posedge clk) disable iff (!rst_n)
		result_success |-> result_valid)
		else $error("result_success raised without result_valid");

	// collector is a single register stage.
	a_valid_after_sc: assert property (@(posedge clk) disable iff (!rst_n)
		(|sc_strobe) |=> result_valid)
		else $error("result_valid missing one cycle after sc_strobe");

	a_valid_needs_sc: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> $past(|sc_strobe))
		else $error("result_valid raised without a preceding sc_strobe");

endmodule : atomic_monitor_props

bind atomic_monitor_top atomic_monitor_props u_props (
	.clk            (clk),
	.rst_n          (rst_n),
	.lr_strobe      (lr_strobe),
	.sc_strobe      (sc_strobe),
	.result_valid   (result_valid),
	.result_success (result_success)
);

// ==== bench/tb_atomic_monitor.sv ====
// testbench for the reservation unit, drives the vector file and checks every SC result.
`timescale 1ns/100ps
`include "amon_cfg.svh"

module tb_atomic_monitor;

	import mon_pkg::*;
	import isa_pkg::*;

	localparam int          MAX_VECS  = 64;
	localparam int          FIELDS    = 5;       // hart, instr, addr, valid, success.
	localparam int          LATENCY   = 2;       // access cycle to result cycle.
	localparam int          DRAIN_MAX = 16;
	localparam logic [31:0] IDLE_LINE = 32'hF;
	localparam logic [31:0] END_LINE  = 32'hE;

	typedef struct packed {
		logic [31:0] due;       // cycle the result shows up in.
		logic        valid;
		logic        success;
		hart_t       hart;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        update;
	hart_t       hart;
	instr_word_u instr;
	addr_t       addr;
	logic        result_valid;
	logic        result_success;
	hart_t       result_hart;

	logic [31:0] vec_mem [0:MAX_VECS*FIELDS-1];
	expect_t     exp_q [$];
	logic [31:0] cycle;
	int          errors;
	int          checks;

	atomic_monitor_top u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.update         (update),
		.hart           (hart),
		.instr          (instr),
		.addr           (addr),
		.result_valid   (result_valid),
		.result_success (result_success),
		.result_hart    (result_hart)
	);

	always #2 clk = ~clk;   // 4 ns period.

	function automatic logic [31:0] vec_field(input int line, input int col);
		return vec_mem[line*FIELDS+col];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at cycle %0d",
				name, got, exp, cycle);
		end
	endtask

	task automatic step();
		@(posedge clk);
		cycle = cycle + 1;
	endtask

	task automatic drive_idle();
		update <= 1'b0;
		hart   <= '0;
		instr  <= '0;
		addr   <= '0;
	endtask

	task automatic drive_access(input int line);
		expect_t e;
		update   <= 1'b1;
		hart     <= hart_t'(vec_field(line, 0));
		instr    <= vec_field(line, 1);
		addr     <= vec_field(line, 2);
		e.due     = cycle + LATENCY;
		e.valid   = vec_field(line, 3) != 0;
		e.success = vec_field(line, 4) != 0;
		e.hart    = hart_t'(vec_field(line, 0));
		exp_q.push_back(e);
	endtask

	// outputs settle well before the falling edge.
	task automatic sample_results();
		expect_t e;
		@(negedge clk);
		if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
			e = exp_q.pop_front();
			check_value("result_valid", 32'(result_valid), 32'(e.valid));
			check_value("result_success", 32'(result_success), 32'(e.success));
			if (e.valid) begin
				check_value("result_hart", 32'(result_hart), 32'(e.hart));
			end
		end else begin
			// nothing due, so no pulse allowed.
			check_value("result_valid", 32'(result_valid), 32'd0);
			check_value("result_success", 32'(result_success), 32'd0);
		end
	endtask

	initial begin
		int          line;
		int          waited;
		logic        at_end;
		logic [31:0] h;
		clk    = 1'b0;
		rst_n  = 1'b0;
		update = 1'b0;
		hart   = '0;
		instr  = '0;
		addr   = '0;
		cycle  = '0;
		errors = 0;
		checks = 0;
		$readmemh("bench/atomic_vectors.txt", vec_mem);

		repeat (2) begin
			step();
		end
		rst_n <= 1'b1;

		line   = 0;
		at_end = 1'b0;
		while (!at_end && line < MAX_VECS) begin
			step();
			h = vec_field(line, 0);
			if (h == END_LINE) begin
				at_end = 1'b1;
				drive_idle();
			end else if (h == IDLE_LINE) begin
				drive_idle();
			end else if (h < `AMON_HARTS) begin
				drive_access(line);
			end else begin
				errors++;
				$display("Error: vector line %0d has an unknown hart field 0x%0h", line, h);
				at_end = 1'b1;
				drive_idle();
			end
			line++;
			sample_results();
		end
		if (!at_end) begin
			errors++;
			$display("Error: vector file has no end marker within %0d lines", MAX_VECS);
		end

		// let the two pipeline stages empty.
		waited = 0;
		while (exp_q.size() > 0 && waited < DRAIN_MAX) begin
			step();
			sample_results();
			waited++;
		end
		if (exp_q.size() > 0) begin
			errors++;
			$display("Error: timed out waiting for %0d outstanding results", exp_q.size());
		end

		// a couple of quiet cycles to catch stray pulses.
		repeat (2) begin
			step();
			sample_results();
		end

		$display("checks run: %0d, errors found: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : tb_atomic_monitor

// ==== project.f ====
+incdir+src
src/isa_pkg.sv
src/mon_pkg.sv
src/access_decoder.sv
src/exclusive_monitor.sv
src/sc_result_collector.sv
src/atomic_monitor_top.sv
bench/atomic_monitor_props.sv
bench/tb_atomic_monitor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f project.f --top-module tb_atomic_monitor -o tb_sim \
	&& ./obj_dir/tb_sim | tee "$log" \
	|| { echo "build or run of the simulation did not complete"; exit 1; }

grep -q "sim failed" "$log" \
	&& { echo "RESULT: FAIL"; exit 1; } \
	|| { echo "RESULT: PASS"; exit 0; }

// ==== bench/atomic_vectors.txt ====
// each line holds hart (F idle, E end), instruction, address, expected valid and success.
// lr.w 100525AF, sc.w 18C525AF, sw 00C52023, lw 00052583, amoadd.w 00C525AF.
F 00000000 00000000 0 0
0 00C52023 00001000 0 0
1 00052583 00001000 0 0
F 00000000 00000000 0 0
0 100525AF 00001000 0 0
0 18C525AF 00001000 1 1
1 100525AF 00002000 0 0
1 18C525AF 00002004 1 0
1 100525AF 00002000 0 0
1 18C525AF 00002003 1 1
2 100525AF 00003000 0 0
3 00C52023 00003000 0 0
F 00000000 00000000 0 0
2 18C525AF 00003000 1 0
2 100525AF 00003000 0 0
3 00C52023 00003010 0 0
1 00052583 00003000 0 0
2 18C525AF 00003000 1 1
3 100525AF 00004000 0 0
3 100525AF 00004100 0 0
3 18C525AF 00004100 1 1
3 18C525AF 00004000 1 1
3 100525AF 00004000 0 0
3 100525AF 00004100 0 0
0 00C525AF 00004100 0 0
3 18C525AF 00004100 1 0
3 18C525AF 00004000 1 1
0 100525AF 00005000 0 0
1 100525AF 00005100 0 0
2 100525AF 00005200 0 0
3 100525AF 00005300 0 0
0 00C52023 00005200 0 0
0 18C525AF 00005000 1 1
1 18C525AF 00005100 1 1
2 18C525AF 00005200 1 0
3 18C525AF 00005300 1 1
E 00000000 00000000 0 0
